/* all.f */
source/sdram_slot_pkg.sv
source/slot_ram.sv
source/slot_rom.sv
source/bank_arbiter.sv
source/sdram_slots.sv
test/sdram_bank_model.sv
test/tb_sdram_slots.sv

/* Bender.yml */
package:
  name: sdram_slots

sources:
  - source/sdram_slot_pkg.sv
  - source/slot_ram.sv
  - source/slot_rom.sv
  - source/bank_arbiter.sv
  - source/sdram_slots.sv
  - target: test
    files:
      - test/sdram_bank_model.sv
      - test/tb_sdram_slots.sv

/* test/tb_sdram_slots.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_slots;

    localparam int N_ROM = 24;
    localparam int N_SND = 24;
    localparam int N_RAM = 16;
    localparam int N_HIT = 8;
    localparam int N_MIX = 20;
    localparam int ACCESSES    = N_ROM + N_SND + 2 * N_RAM + 2 * N_HIT + 3 * N_MIX;
    localparam int CYCLE_LIMIT = 200 * ACCESSES;
    localparam logic [15:0] FILL = 16'h5a3c;

    logic        clk;
    logic        arst_n;
    logic        ram_cs;
    logic        ram_wen;
    logic [16:0] ram_addr;
    logic [15:0] ram_din;
    logic [1:0]  ram_wrmask;
    wire         ram_ok;
    wire  [15:0] ram_dout;
    logic        rom_cs;
    logic [20:0] rom_addr;
    wire         rom_ok;
    wire  [15:0] rom_dout;
    logic        snd_cs;
    logic [15:0] snd_addr;
    wire         snd_ok;
    wire  [7:0]  snd_dout;

    sdram_slot_pkg::sdram_addr_t sdram_addr;
    sdram_slot_pkg::sdram_word_t data_read;
    logic        sdram_rd;
    logic        sdram_wr;
    logic [15:0] sdram_din;
    logic [1:0]  sdram_wrmask;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    logic [1:0]  ack_rnd;
    logic [1:0]  dst_rnd;
    int          txn_count;

    int          cycles;
    logic [15:0] stim_lfsr = 16'd3;
    logic [15:0] bank_lfsr = 16'd3;
    logic [31:0] delay_bits;
    logic [15:0] mirror [sdram_slot_pkg::sdram_addr_t];   // Expected bank contents

    sdram_slots dut0 (
        .clk (clk), .arst_n (arst_n),
        .ram_cs (ram_cs), .ram_wen (ram_wen), .ram_addr (ram_addr), .ram_din (ram_din),
        .ram_wrmask (ram_wrmask), .ram_ok (ram_ok), .ram_dout (ram_dout),
        .rom_cs (rom_cs), .rom_addr (rom_addr), .rom_ok (rom_ok), .rom_dout (rom_dout),
        .snd_cs (snd_cs), .snd_addr (snd_addr), .snd_ok (snd_ok), .snd_dout (snd_dout),
        .sdram_addr (sdram_addr), .sdram_rd (sdram_rd), .sdram_wr (sdram_wr),
        .sdram_din (sdram_din), .sdram_wrmask (sdram_wrmask), .sdram_ack (sdram_ack),
        .data_dst (data_dst), .data_rdy (data_rdy), .data_read (data_read)
    );

    sdram_bank_model #(.FILL (FILL)) u_bank (
        .clk (clk), .arst_n (arst_n),
        .sdram_addr (sdram_addr), .sdram_rd (sdram_rd), .sdram_wr (sdram_wr),
        .sdram_din (sdram_din), .sdram_wrmask (sdram_wrmask),
        .ack_rnd (ack_rnd), .dst_rnd (dst_rnd),
        .sdram_ack (sdram_ack), .data_dst (data_dst), .data_rdy (data_rdy),
        .data_read (data_read), .txn_count (txn_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(inout logic [15:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);
            v = {v[30:0], s[0]};
        end
    endtask

    // Untouched words carry every address bit
    function automatic sdram_slot_pkg::sdram_word_t expected_word(
        input sdram_slot_pkg::sdram_addr_t a
    );
        sdram_slot_pkg::sdram_word_t w;
        w.word = mirror.exists(a) ? mirror[a] : a[15:0] ^ {a[22:16], 9'd0} ^ FILL;
        return w;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string name, input sdram_slot_pkg::sdram_word_t exp,
                              input sdram_slot_pkg::sdram_word_t act);
        if (act.word !== exp.word) begin
            report_failure($sformatf("error %s: expected %h, actual %h",
                                     name, exp.word, act.word));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            report_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_wait(input string name, input int txns);
        if (txns > sdram_slot_pkg::slot_count) begin
            report_failure($sformatf("%s waited through %0d bank transactions, more than %0d",
                                     name, txns, sdram_slot_pkg::slot_count));
        end
    endtask

    // Access tasks start and end 1 ns after a rising edge
    task automatic rom_read(input string name, input logic [20:0] a, output int lat);
        sdram_slot_pkg::sdram_word_t exp;
        int t0;
        exp      = expected_word(sdram_slot_pkg::rom_offset + sdram_slot_pkg::sdram_addr_t'(a));
        rom_cs   = 1'b1;
        rom_addr = a;
        t0       = txn_count;
        lat      = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!rom_ok);
        check_word($sformatf("%s @%h", name, a), exp, rom_dout);
        check_wait($sformatf("%s @%h", name, a), txn_count - t0);
        rom_cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic snd_read(input string name, input logic [15:0] a);
        sdram_slot_pkg::sdram_word_t w;
        logic [7:0] exp;
        int t0;
        w        = expected_word(sdram_slot_pkg::snd_offset
                                 + sdram_slot_pkg::sdram_addr_t'(a[15:1]));
        exp      = a[0] ? w.bytes.hi : w.bytes.lo;    // Odd byte is the high half
        snd_cs   = 1'b1;
        snd_addr = a;
        t0       = txn_count;
        do begin
            @(posedge clk);
            #1;
        end while (!snd_ok);
        check_byte($sformatf("%s @%h", name, a), exp, snd_dout);
        check_wait($sformatf("%s @%h", name, a), txn_count - t0);
        snd_cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic ram_access(input string name, input logic wen, input logic [16:0] a,
                              input logic [15:0] d, input logic [1:0] m);
        sdram_slot_pkg::sdram_addr_t bank;
        sdram_slot_pkg::sdram_word_t w;
        int t0;
        bank       = sdram_slot_pkg::wram_offset + sdram_slot_pkg::sdram_addr_t'(a);
        ram_cs     = 1'b1;
        ram_wen    = wen;
        ram_addr   = a;
        ram_din    = d;
        ram_wrmask = m;
        t0         = txn_count;
        do begin
            @(posedge clk);
            #1;
        end while (!ram_ok);
        check_wait($sformatf("%s @%h", name, a), txn_count - t0);
        w = expected_word(bank);
        if (wen) begin
            if (!m[1]) w.bytes.hi = d[15:8];
            if (!m[0]) w.bytes.lo = d[7:0];
            mirror[bank] = w.word;
        end else begin
            check_word($sformatf("%s @%h", name, a), w, ram_dout);
        end
        ram_cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        random_bits(bank_lfsr, 4, delay_bits);
        ack_rnd = delay_bits[1:0];
        dst_rnd = delay_bits[3:2];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            report_failure($sformatf("timeout: run still busy after %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        logic [31:0] r;
        int lat;
        int lat_mix;
        logic        mix_wen  [N_MIX];
        logic [16:0] mix_ram  [N_MIX];
        logic [15:0] mix_data [N_MIX];
        logic [1:0]  mix_mask [N_MIX];
        logic [20:0] mix_rom  [N_MIX];
        logic [15:0] mix_snd  [N_MIX];
        cycles     = 0;
        arst_n     = 1'b0;
        ram_cs     = 1'b0;
        ram_wen    = 1'b0;
        ram_addr   = '0;
        ram_din    = '0;
        ram_wrmask = 2'b11;
        rom_cs     = 1'b0;
        rom_addr   = '0;
        snd_cs     = 1'b0;
        snd_addr   = '0;
        ack_rnd    = 2'd0;
        dst_rnd    = 2'd0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_bit("reset ram_ok", 1'b0, ram_ok);
        check_bit("reset rom_ok", 1'b0, rom_ok);
        check_bit("reset snd_ok", 1'b0, snd_ok);
        check_bit("reset sdram_rd", 1'b0, sdram_rd);
        check_bit("reset sdram_wr", 1'b0, sdram_wr);

        for (int i = 0; i < N_ROM; i++) begin
            random_bits(stim_lfsr, 21, r);
            rom_read("rom read", r[20:0], lat);
        end
        for (int i = 0; i < N_SND; i++) begin
            random_bits(stim_lfsr, 16, r);
            snd_read("snd read", r[15:0]);
        end
        for (int i = 0; i < N_RAM; i++) begin
            random_bits(stim_lfsr, 17, r);
            ram_addr = r[16:0];
            random_bits(stim_lfsr, 18, r);
            ram_access("ram write", 1'b1, ram_addr, r[15:0], r[17:16]);
            ram_access("ram read back", 1'b0, ram_addr, 16'h0000, 2'b11);
        end

        // Second read of the same word comes from the latch
        for (int i = 0; i < N_HIT; i++) begin
            random_bits(stim_lfsr, 21, r);
            rom_read("rom miss", r[20:0], lat);
            rom_read("rom hit", r[20:0], lat);
            check_count("rom hit latency", 1, lat);
        end

        // Narrow windows so the mixed run sees hits and read after write
        for (int i = 0; i < N_MIX; i++) begin
            random_bits(stim_lfsr, 23, r);
            mix_wen[i]  = r[22];
            mix_ram[i]  = {13'd0, r[3:0]};
            mix_mask[i] = r[5:4];
            mix_data[i] = r[21:6];
            random_bits(stim_lfsr, 8, r);
            mix_rom[i]  = {18'd0, r[2:0]};
            mix_snd[i]  = {11'd0, r[7:3]};
        end
        fork
            begin
                for (int i = 0; i < N_MIX; i++) begin
                    ram_access("mixed ram", mix_wen[i], mix_ram[i], mix_data[i], mix_mask[i]);
                end
            end
            begin
                for (int i = 0; i < N_MIX; i++) begin
                    rom_read("mixed rom", mix_rom[i], lat_mix);
                end
            end
            begin
                for (int i = 0; i < N_MIX; i++) begin
                    snd_read("mixed snd", mix_snd[i]);
                end
            end
        join

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* test/sdram_bank_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_model #(
    parameter logic [15:0] FILL = 16'h5a3c    // XOR pattern of untouched words
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire sdram_slot_pkg::sdram_addr_t sdram_addr,
    input  wire                              sdram_rd,
    input  wire                              sdram_wr,
    input  wire  [15:0]                      sdram_din,
    input  wire  [1:0]                       sdram_wrmask,
    input  wire  [1:0]                       ack_rnd,     // Fresh random bits every cycle
    input  wire  [1:0]                       dst_rnd,
    output logic                             sdram_ack,
    output logic                             data_dst,
    output logic                             data_rdy,
    output sdram_slot_pkg::sdram_word_t      data_read,
    output int                               txn_count    // Transactions closed so far
);

    logic [15:0] mem [sdram_slot_pkg::sdram_addr_t];    // Only written words are stored
    logic [2:0]  st;
    logic [1:0]  cnt;
    logic [15:0] merged;

    // Upper address bits land in the top of the word so regions differ
    function automatic logic [15:0] peek(input sdram_slot_pkg::sdram_addr_t a);
        return mem.exists(a) ? mem[a] : a[15:0] ^ {a[22:16], 9'd0} ^ FILL;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st        <= 3'd0;
            cnt       <= 2'd0;
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            txn_count <= 0;
        end else begin
            case (st)
                3'd0: begin
                    if (sdram_rd || sdram_wr) begin
                        cnt <= (ack_rnd == 2'd3) ? 2'd2 : ack_rnd;   // Ack in 1 to 3 cycles
                        st  <= 3'd1;
                    end
                end
                3'd1: begin
                    if (cnt == 2'd0) begin
                        sdram_ack <= 1'b1;
                        cnt       <= dst_rnd;                        // dst in 1 to 4 cycles
                        st        <= 3'd2;
                        if (sdram_wr) begin
                            merged = peek(sdram_addr);
                            if (!sdram_wrmask[1]) merged[15:8] = sdram_din[15:8];
                            if (!sdram_wrmask[0]) merged[7:0] = sdram_din[7:0];
                            mem[sdram_addr] = merged;
                        end
                    end else begin
                        cnt <= cnt - 2'd1;
                    end
                end
                3'd2: begin
                    sdram_ack <= 1'b0;
                    if (cnt == 2'd0) begin
                        data_dst <= 1'b1;
                        st       <= 3'd3;
                    end else begin
                        cnt <= cnt - 2'd1;
                    end
                end
                3'd3: begin
                    data_dst       <= 1'b0;
                    data_rdy       <= 1'b1;
                    data_read.word <= peek(sdram_addr);  // Arbiter holds the address until rdy
                    txn_count      <= txn_count + 1;
                    st             <= 3'd4;
                end
                default: begin
                    data_rdy <= 1'b0;
                    st       <= 3'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/sdram_slots.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_slots #(
    parameter int WRAM_AW = 17,
    parameter int PROM_AW = 21,
    parameter int SROM_AW = 16      // Byte address
) (
    input  wire                          clk,
    input  wire                          arst_n,
    // Main CPU work RAM
    input  wire                          ram_cs,
    input  wire                          ram_wen,
    input  wire  [WRAM_AW-1:0]           ram_addr,
    input  wire  [15:0]                  ram_din,
    input  wire  [1:0]                   ram_wrmask,
    output wire                          ram_ok,
    output wire  [15:0]                  ram_dout,
    // Main CPU program ROM
    input  wire                          rom_cs,
    input  wire  [PROM_AW-1:0]           rom_addr,
    output wire                          rom_ok,
    output wire  [15:0]                  rom_dout,
    // Sound CPU ROM
    input  wire                          snd_cs,
    input  wire  [SROM_AW-1:0]           snd_addr,
    output wire                          snd_ok,
    output wire  [7:0]                   snd_dout,
    // SDRAM bank
    output wire sdram_slot_pkg::sdram_addr_t sdram_addr,
    output wire                          sdram_rd,
    output wire                          sdram_wr,
    output wire  [15:0]                  sdram_din,
    output wire  [1:0]                   sdram_wrmask,
    input  wire                          sdram_ack,
    input  wire                          data_dst,
    input  wire                          data_rdy,
    input  wire sdram_slot_pkg::sdram_word_t data_read
);

    localparam int N = sdram_slot_pkg::slot_count;

    // Slot 0 work RAM, 1 program ROM, 2 sound ROM
    wire [N-1:0] req;
    wire [N-1:0] gnt;
    wire [N-1:0] dst;
    wire [N-1:0] rdy;
    wire sdram_slot_pkg::sdram_addr_t req_addr [N];
    wire         req_wr;
    wire [15:0]  req_din;
    wire [1:0]   req_mask;

    slot_ram #(
        .AW        ( WRAM_AW     ),
        .DW        ( 16          )
    ) u_wram (
        .clk       ( clk         ),
        .arst_n    ( arst_n      ),
        .cs        ( ram_cs      ),
        .wen       ( ram_wen     ),
        .addr      ( ram_addr    ),
        .din       ( ram_din     ),
        .wrmask    ( ram_wrmask  ),
        .ok        ( ram_ok      ),
        .dout      ( ram_dout    ),
        .req       ( req[0]      ),
        .req_addr  ( req_addr[0] ),
        .req_wr    ( req_wr      ),
        .req_din   ( req_din     ),
        .req_mask  ( req_mask    ),
        .gnt       ( gnt[0]      ),
        .dst       ( dst[0]      ),
        .rdy       ( rdy[0]      ),
        .data_read ( data_read   )
    );

    slot_rom #(
        .AW        ( PROM_AW     ),
        .DW        ( 16          )
    ) u_prom (
        .clk       ( clk         ),
        .arst_n    ( arst_n      ),
        .cs        ( rom_cs      ),
        .addr      ( rom_addr    ),
        .ok        ( rom_ok      ),
        .dout      ( rom_dout    ),
        .req       ( req[1]      ),
        .req_addr  ( req_addr[1] ),
        .gnt       ( gnt[1]      ),
        .dst       ( dst[1]      ),
        .rdy       ( rdy[1]      ),
        .data_read ( data_read   )
    );

    slot_rom #(
        .AW        ( SROM_AW     ),
        .DW        ( 8           )
    ) u_srom (
        .clk       ( clk         ),
        .arst_n    ( arst_n      ),
        .cs        ( snd_cs      ),
        .addr      ( snd_addr    ),
        .ok        ( snd_ok      ),
        .dout      ( snd_dout    ),
        .req       ( req[2]      ),
        .req_addr  ( req_addr[2] ),
        .gnt       ( gnt[2]      ),
        .dst       ( dst[2]      ),
        .rdy       ( rdy[2]      ),
        .data_read ( data_read   )
    );

    bank_arbiter #(
        .OFFSET0      ( sdram_slot_pkg::wram_offset ),
        .OFFSET1      ( sdram_slot_pkg::rom_offset  ),
        .OFFSET2      ( sdram_slot_pkg::snd_offset  )
    ) u_arb (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .req0         ( req[0]       ),
        .req1         ( req[1]       ),
        .req2         ( req[2]       ),
        .req_addr0    ( req_addr[0]  ),
        .req_addr1    ( req_addr[1]  ),
        .req_addr2    ( req_addr[2]  ),
        .req_wr0      ( req_wr       ),
        .req_din0     ( req_din      ),
        .req_mask0    ( req_mask     ),
        .gnt0         ( gnt[0]       ),
        .gnt1         ( gnt[1]       ),
        .gnt2         ( gnt[2]       ),
        .dst0         ( dst[0]       ),
        .dst1         ( dst[1]       ),
        .dst2         ( dst[2]       ),
        .rdy0         ( rdy[0]       ),
        .rdy1         ( rdy[1]       ),
        .rdy2         ( rdy[2]       ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_rd     ( sdram_rd     ),
        .sdram_wr     ( sdram_wr     ),
        .sdram_din    ( sdram_din    ),
        .sdram_wrmask ( sdram_wrmask ),
        .sdram_ack    ( sdram_ack    ),
        .data_dst     ( data_dst     ),
        .data_rdy     ( data_rdy     )
    );

endmodule

`default_nettype wire

/* source/bank_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter #(
    parameter sdram_slot_pkg::sdram_addr_t OFFSET0 = sdram_slot_pkg::wram_offset,
    parameter sdram_slot_pkg::sdram_addr_t OFFSET1 = sdram_slot_pkg::rom_offset,
    parameter sdram_slot_pkg::sdram_addr_t OFFSET2 = sdram_slot_pkg::snd_offset
) (
    input  wire                          clk,
    input  wire                          arst_n,
    // Requests
    input  wire                          req0,
    input  wire                          req1,
    input  wire                          req2,
    input  wire sdram_slot_pkg::sdram_addr_t req_addr0,
    input  wire sdram_slot_pkg::sdram_addr_t req_addr1,
    input  wire sdram_slot_pkg::sdram_addr_t req_addr2,
    input  wire                          req_wr0,   // Slot 0 is the only writer
    input  wire  [15:0]                  req_din0,
    input  wire  [1:0]                   req_mask0,
    // Responses
    output logic                         gnt0,
    output logic                         gnt1,
    output logic                         gnt2,
    output logic                         dst0,
    output logic                         dst1,
    output logic                         dst2,
    output logic                         rdy0,
    output logic                         rdy1,
    output logic                         rdy2,
    // Bank side
    output sdram_slot_pkg::sdram_addr_t  sdram_addr,
    output logic                         sdram_rd,
    output logic                         sdram_wr,
    output logic [15:0]                  sdram_din,
    output logic [1:0]                   sdram_wrmask,
    input  wire                          sdram_ack,
    input  wire                          data_dst,
    input  wire                          data_rdy
);

    localparam int N  = sdram_slot_pkg::slot_count;
    localparam int OW = $clog2(N);

    logic [N-1:0]  req_v;
    logic [N-1:0]  own_v;       // One-hot owner while busy
    logic [OW-1:0] ptr;         // Highest priority slot
    logic [OW-1:0] owner;
    logic [OW-1:0] pick;
    logic          busy;
    logic          any_req;
    logic          acked;
    logic          pick_wr;
    sdram_slot_pkg::sdram_addr_t pick_addr;

    assign req_v   = {req2, req1, req0};
    assign own_v   = busy ? {{(N-1){1'b0}}, 1'b1} << owner : '0;
    assign acked   = sdram_ack && (sdram_rd || sdram_wr);
    assign pick_wr = pick == '0 && req_wr0;

    assign gnt0 = own_v[0] && acked;
    assign gnt1 = own_v[1] && acked;
    assign gnt2 = own_v[2] && acked;
    assign dst0 = own_v[0] && data_dst;
    assign dst1 = own_v[1] && data_dst;
    assign dst2 = own_v[2] && data_dst;
    assign rdy0 = own_v[0] && data_rdy;
    assign rdy1 = own_v[1] && data_rdy;
    assign rdy2 = own_v[2] && data_rdy;

    // Scan from the far end so the slot nearest ptr wins
    always_comb begin
        int idx;
        pick    = ptr;
        any_req = 1'b0;
        for (int k = N - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % N;
            if (req_v[idx]) begin
                pick    = idx[OW-1:0];
                any_req = 1'b1;
            end
        end
    end

    always_comb begin
        case (pick)
            2'd0:    pick_addr = OFFSET0 + req_addr0;
            2'd1:    pick_addr = OFFSET1 + req_addr1;
            default: pick_addr = OFFSET2 + req_addr2;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            owner    <= '0;
            ptr      <= '0;
            sdram_rd <= 1'b0;
            sdram_wr <= 1'b0;
        end else if (!busy) begin
            if (any_req) begin
                busy     <= 1'b1;
                owner    <= pick;
                sdram_wr <= pick_wr;
                sdram_rd <= !pick_wr;
            end
        end else begin
            if (sdram_ack) begin
                sdram_rd <= 1'b0;
                sdram_wr <= 1'b0;
            end
            if (data_rdy) begin
                busy <= 1'b0;
                ptr  <= (owner == OW'(N - 1)) ? '0 : owner + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && any_req) begin
            sdram_addr   <= pick_addr;
            sdram_din    <= req_din0;
            sdram_wrmask <= req_mask0;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({gnt2, gnt1, gnt0}));

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(sdram_rd && sdram_wr));

endmodule

`default_nettype wire

/* source/slot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_rom #(
    parameter int AW = 21,
    parameter int DW = 16     // 8 or 16
) (
    input  wire                          clk,
    input  wire                          arst_n,
    // Client side
    input  wire                          cs,
    input  wire  [AW-1:0]                addr,
    output logic                         ok,
    output logic [DW-1:0]                dout,
    // Arbiter side
    output logic                         req,
    output sdram_slot_pkg::sdram_addr_t  req_addr,
    input  wire                          gnt,
    input  wire                          dst,
    input  wire                          rdy,
    input  wire sdram_slot_pkg::sdram_word_t data_read
);

    // Byte wide clients address bytes, the bank holds words
    localparam int WAW = (DW == 8) ? AW - 1 : AW;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_GNT  = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0]     state;
    logic           data_due;
    logic           abandon;
    logic           cache_ok;     // Latch holds a fetched word
    logic           start;
    logic           hit;
    logic           take;
    logic           odd_l;
    logic [WAW-1:0] word_addr;
    logic [WAW-1:0] fetch_addr;
    logic [WAW-1:0] cache_addr;
    sdram_slot_pkg::sdram_word_t cache_word;

    assign word_addr = addr[AW-1:AW-WAW];
    assign hit       = cache_ok && cache_addr == word_addr;
    assign start     = state == ST_IDLE && cs && !ok;
    assign take      = state == ST_DATA && rdy && (data_due || dst);
    assign req       = state != ST_IDLE;
    assign req_addr  = sdram_slot_pkg::sdram_addr_t'(fetch_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            ok       <= 1'b0;
            data_due <= 1'b0;
            abandon  <= 1'b0;
            cache_ok <= 1'b0;
        end else begin
            ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start && hit) begin
                        ok <= 1'b1;             // Answered from the latch
                    end else if (start) begin
                        state   <= ST_GNT;
                        abandon <= 1'b0;
                    end
                end
                ST_GNT: begin
                    if (gnt) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (dst) begin
                        data_due <= 1'b1;
                    end
                    if (take) begin
                        state    <= ST_IDLE;
                        data_due <= 1'b0;
                        cache_ok <= 1'b1;
                        ok       <= cs && !abandon;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (state != ST_IDLE && !cs) begin
                abandon <= 1'b1;
            end
        end
    end

    // An abandoned fetch still refills the latch
    always_ff @(posedge clk) begin
        if (start) begin
            fetch_addr <= word_addr;
            odd_l      <= addr[0];
        end
        if (take) begin
            cache_word <= data_read;
            cache_addr <= fetch_addr;
        end
    end

    generate
        if (DW == 8) begin : g_byte
            assign dout = odd_l ? cache_word.bytes.hi : cache_word.bytes.lo;
        end else begin : g_word
            assign dout = cache_word.word;
        end
    endgenerate

    // Both the hit path and the bank path must answer a live request
    a_ok_needs_cs: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ok) |-> $past(cs));

endmodule

`default_nettype wire

/* source/slot_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_ram #(
    parameter int AW = 17,
    parameter int DW = 16
) (
    input  wire                          clk,
    input  wire                          arst_n,
    // Client side
    input  wire                          cs,
    input  wire                          wen,
    input  wire  [AW-1:0]                addr,
    input  wire  [DW-1:0]                din,
    input  wire  [DW/8-1:0]              wrmask,    // Active low byte enables
    output logic                         ok,
    output logic [DW-1:0]                dout,
    // Arbiter side
    output logic                         req,
    output sdram_slot_pkg::sdram_addr_t  req_addr,
    output logic                         req_wr,
    output logic [DW-1:0]                req_din,
    output logic [DW/8-1:0]              req_mask,
    input  wire                          gnt,
    input  wire                          dst,
    input  wire                          rdy,
    input  wire sdram_slot_pkg::sdram_word_t data_read
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_GNT  = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    logic [1:0]    state;
    logic          data_due;    // dst seen, word on its way
    logic          abandon;     // Client dropped cs mid access
    logic          start;
    logic          take;
    logic [AW-1:0] addr_l;

    // ok still high means the client has not yet moved on
    assign start    = state == ST_IDLE && cs && !ok;
    assign take     = state == ST_DATA && rdy && (data_due || dst);
    assign req      = state != ST_IDLE;
    assign req_addr = sdram_slot_pkg::sdram_addr_t'(addr_l);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            ok       <= 1'b0;
            data_due <= 1'b0;
            abandon  <= 1'b0;
            req_wr   <= 1'b0;
        end else begin
            ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_GNT;
                        req_wr  <= wen;
                        abandon <= 1'b0;
                    end
                end
                ST_GNT: begin
                    if (gnt) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (dst) begin
                        data_due <= 1'b1;
                    end
                    if (take) begin
                        state    <= ST_IDLE;
                        data_due <= 1'b0;
                        ok       <= cs && !abandon;   // Late data is dropped
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (state != ST_IDLE && !cs) begin
                abandon <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_l   <= addr;
            req_din  <= din;
            req_mask <= wrmask;
        end
        if (take && !req_wr) begin
            dout <= data_read.word[DW-1:0];
        end
    end

    // The arbiter latches the address once, when it picks this slot
    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        req && $past(req) |-> req_addr == $past(req_addr));

endmodule

`default_nettype wire

/* source/sdram_slot_pkg.sv */
`default_nettype none

package sdram_slot_pkg;

    localparam int sdram_aw = 23;   // Bank word address width

    typedef logic [sdram_aw-1:0] sdram_addr_t;

    // One bank word, read whole or split into its two bytes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } sdram_word_t;

    // Region bases inside the bank
    localparam sdram_addr_t wram_offset = 23'h30_0000;
    localparam sdram_addr_t rom_offset  = 23'h00_0000;
    localparam sdram_addr_t snd_offset  = 23'h38_0000;

    localparam int slot_count = 3;  // Clients sharing the bank

endpackage

`default_nettype wire
